//--- fxp_pkg.sv
`default_nettype none

// Signed 16.16 fixed point used by every stage of the setup pipeline
package fxp_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int FRAC_BITS  = 16;

    // One scalar word
    typedef logic signed [DATA_WIDTH-1:0] fxp_t;

    // Holds the full product of two scalars
    typedef logic signed [2*DATA_WIDTH-1:0] fxp_wide_t;

    // Screen position, x in the upper word
    typedef struct packed {
        fxp_t x;
        fxp_t y;
    } point_t;

endpackage

`default_nettype wire

//--- setup_pkg.sv
`default_nettype none

package setup_pkg;
    import fxp_pkg::*;

    localparam int N_EDGES = 3;

    // Screen size in whole pixels
    localparam int DEF_SCREEN_W = 640;
    localparam int DEF_SCREEN_H = 360;

    typedef struct packed {
        fxp_t x;
        fxp_t y;
        fxp_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Empty box has valid low
    typedef struct packed {
        point_t tl;
        point_t br;
        logic   valid;
    } bbox_t;

    // Edge va to vb, evaluated at p
    typedef struct packed {
        point_t va;
        point_t vb;
        point_t p;
    } edge_job_t;

    typedef struct packed {
        fxp_t value;
        fxp_t dx;
        fxp_t dy;
    } edge_result_t;

    typedef struct packed {
        bbox_t                            bbox;
        edge_result_t [N_EDGES-1:0]       edges;
        fxp_t                             area;
        fxp_t                             z0;
        fxp_t                             z1;
        fxp_t                             z2;
    } setup_result_t;

endpackage

`default_nettype wire

//--- tri_capture.sv
`default_nettype none

module tri_capture #(
    parameter int SCREEN_W = setup_pkg::DEF_SCREEN_W,
    parameter int SCREEN_H = setup_pkg::DEF_SCREEN_H
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_advance,
    input  logic                  i_dv,
    input  setup_pkg::triangle_t  i_tri,

    output logic                  o_valid,
    output setup_pkg::bbox_t      o_bbox,
    output fxp_pkg::fxp_t         o_z [3],
    output setup_pkg::edge_job_t  o_jobs [setup_pkg::N_EDGES],

    output logic                  o_side_valid,
    output setup_pkg::bbox_t      o_side_bbox,
    output fxp_pkg::fxp_t         o_side_z [3]
);
    import fxp_pkg::*;
    import setup_pkg::*;

    localparam fxp_t SCREEN_W_FP = fxp_t'(SCREEN_W) << FRAC_BITS;
    localparam fxp_t SCREEN_H_FP = fxp_t'(SCREEN_H) << FRAC_BITS;

    function automatic fxp_t min3(input fxp_t a, input fxp_t b, input fxp_t c);
        fxp_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic fxp_t max3(input fxp_t a, input fxp_t b, input fxp_t c);
        fxp_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic point_t to_point(input vertex_t v);
        point_t p;
        p.x = v.x;
        p.y = v.y;
        return p;
    endfunction

    vertex_t   w_verts [3];
    point_t    w_min;
    point_t    w_max;
    bbox_t     w_bbox;
    edge_job_t w_jobs [N_EDGES];

    always_comb begin
        w_verts = '{i_tri.v0, i_tri.v1, i_tri.v2};

        w_min.x = min3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x);
        w_min.y = min3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y);
        w_max.x = max3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x);
        w_max.y = max3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y);

        // Clamp to the screen
        w_bbox.tl.x  = (w_min.x < 0) ? fxp_t'(0) : w_min.x;
        w_bbox.tl.y  = (w_min.y < 0) ? fxp_t'(0) : w_min.y;
        w_bbox.br.x  = (w_max.x > SCREEN_W_FP) ? SCREEN_W_FP : w_max.x;
        w_bbox.br.y  = (w_max.y > SCREEN_H_FP) ? SCREEN_H_FP : w_max.y;
        w_bbox.valid = (w_bbox.tl.x < w_bbox.br.x) && (w_bbox.tl.y < w_bbox.br.y);

        // Edges v0->v1, v1->v2, v2->v0, all sampled at the box corner
        for (int e = 0; e < N_EDGES; e++) begin
            w_jobs[e].va = to_point(w_verts[e]);
            w_jobs[e].vb = to_point(w_verts[(e + 1) % 3]);
            w_jobs[e].p  = w_bbox.tl;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid      <= 1'b0;
            o_side_valid <= 1'b0;
        end else if (i_advance) begin
            o_valid      <= i_dv;
            o_side_valid <= o_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_bbox      <= w_bbox;
            o_z         <= '{i_tri.v0.z, i_tri.v1.z, i_tri.v2.z};
            o_jobs      <= w_jobs;
            // Second copy lines up with the edge unit outputs
            o_side_bbox <= o_bbox;
            o_side_z    <= o_z;
        end
    end

    a_bbox_order: assert property (@(posedge clk) disable iff (!rstn)
        o_valid && o_bbox.valid |->
            (o_bbox.tl.x <= o_bbox.br.x) && (o_bbox.tl.y <= o_bbox.br.y));

endmodule

`default_nettype wire

//--- edge_unit.sv
`default_nettype none

module edge_unit (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_advance,
    input  setup_pkg::edge_job_t     i_job,
    output setup_pkg::edge_result_t  o_edge
);
    import fxp_pkg::*;
    import setup_pkg::*;

    // Differences kept wide so they never wrap before the multiply
    fxp_wide_t    w_px;
    fxp_wide_t    w_py;
    fxp_wide_t    w_ex;
    fxp_wide_t    w_ey;
    fxp_wide_t    w_func;
    edge_result_t w_edge;

    always_comb begin
        w_px = fxp_wide_t'(i_job.p.x) - fxp_wide_t'(i_job.va.x);
        w_py = fxp_wide_t'(i_job.p.y) - fxp_wide_t'(i_job.va.y);
        w_ex = fxp_wide_t'(i_job.vb.x) - fxp_wide_t'(i_job.va.x);
        w_ey = fxp_wide_t'(i_job.vb.y) - fxp_wide_t'(i_job.va.y);

        w_func = (w_px * w_ey) - (w_py * w_ex);

        // Product is 32.32, take back the 16.16 middle
        w_edge.value = w_func[DATA_WIDTH+FRAC_BITS-1:FRAC_BITS];

        // Per-pixel steps
        w_edge.dx = i_job.vb.y - i_job.va.y;
        w_edge.dy = i_job.va.x - i_job.vb.x;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_edge <= '0;
        end else if (i_advance) begin
            o_edge <= w_edge;
        end
    end

    a_dx_step: assert property (@(posedge clk)
        rstn && i_advance |=> o_edge.dx == ($past(i_job.vb.y) - $past(i_job.va.y)));

endmodule

`default_nettype wire

//--- setup_collect.sv
`default_nettype none

module setup_collect (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_ready,

    input  logic                     i_valid,
    input  setup_pkg::bbox_t         i_bbox,
    input  fxp_pkg::fxp_t            i_z [3],
    input  setup_pkg::edge_result_t  i_edges [setup_pkg::N_EDGES],

    output logic                     o_advance,
    output logic                     o_dv,
    output logic                     o_culled,
    output setup_pkg::setup_result_t o_result
);
    import fxp_pkg::*;
    import setup_pkg::*;

    fxp_t          w_area;
    logic          w_culled;
    setup_result_t w_result;

    // Whole pipeline moves when the output slot is free or being drained
    assign o_advance = !o_dv || i_ready;

    always_comb begin
        // Edge values at one point add up to the doubled area
        w_area = fxp_t'(0);
        for (int e = 0; e < N_EDGES; e++) begin
            w_area = w_area + i_edges[e].value;
        end

        w_culled = (w_area <= 0) || !i_bbox.valid;

        w_result.bbox = i_bbox;
        for (int e = 0; e < N_EDGES; e++) begin
            w_result.edges[e] = i_edges[e];
        end
        w_result.area = w_area;
        w_result.z0   = i_z[0];
        w_result.z1   = i_z[1];
        w_result.z2   = i_z[2];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_dv     <= 1'b0;
            o_culled <= 1'b0;
        end else if (o_advance) begin
            o_dv     <= i_valid;
            o_culled <= i_valid && w_culled;
        end
    end

    always_ff @(posedge clk) begin
        if (o_advance) begin
            o_result <= w_result;
        end
    end

    // Stalled output must not move
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_dv && !i_ready |=> o_dv && $stable(o_result) && $stable(o_culled));

    a_reset_dv: assert property (@(posedge clk) !rstn |=> !o_dv);

endmodule

`default_nettype wire

//--- tri_setup.sv
`default_nettype none

module tri_setup #(
    parameter int SCREEN_W = setup_pkg::DEF_SCREEN_W,
    parameter int SCREEN_H = setup_pkg::DEF_SCREEN_H
) (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic                     i_dv,
    input  setup_pkg::triangle_t     i_tri,
    output logic                     o_ready,

    output logic                     o_dv,
    output logic                     o_culled,
    output setup_pkg::setup_result_t o_result,
    input  logic                     i_ready
);
    import fxp_pkg::*;
    import setup_pkg::*;

    logic         w_advance;
    edge_job_t    w_jobs [N_EDGES];
    edge_result_t w_edges [N_EDGES];

    logic         w_side_valid;
    bbox_t        w_side_bbox;
    fxp_t         w_side_z [3];

    assign o_ready = w_advance;

    tri_capture #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) i_tri_capture (
        .clk          (clk),
        .rstn         (rstn),
        .i_advance    (w_advance),
        .i_dv         (i_dv),
        .i_tri        (i_tri),
        // Stage one fields reach the output through the delayed copy
        .o_valid      (),
        .o_bbox       (),
        .o_z          (),
        .o_jobs       (w_jobs),
        .o_side_valid (w_side_valid),
        .o_side_bbox  (w_side_bbox),
        .o_side_z     (w_side_z)
    );

    for (genvar g = 0; g < N_EDGES; g++) begin : g_edge
        edge_unit i_edge_unit (
            .clk       (clk),
            .rstn      (rstn),
            .i_advance (w_advance),
            .i_job     (w_jobs[g]),
            .o_edge    (w_edges[g])
        );
    end

    setup_collect i_setup_collect (
        .clk       (clk),
        .rstn      (rstn),
        .i_ready   (i_ready),
        .i_valid   (w_side_valid),
        .i_bbox    (w_side_bbox),
        .i_z       (w_side_z),
        .i_edges   (w_edges),
        .o_advance (w_advance),
        .o_dv      (o_dv),
        .o_culled  (o_culled),
        .o_result  (o_result)
    );

endmodule

`default_nettype wire

//--- tb_tri_setup.sv
`default_nettype none

module tb_tri_setup;
    import fxp_pkg::*;
    import setup_pkg::*;

    localparam int N_RANDOM   = 200;
    localparam int N_STREAM   = 40;
    localparam int N_TRIS     = 10 + N_RANDOM;
    localparam int MAX_CYCLES = 20 * N_TRIS + 100;

    logic          clk;
    logic          rstn;
    logic          i_dv;
    triangle_t     i_tri;
    logic          o_ready;
    logic          o_dv;
    logic          o_culled;
    setup_result_t o_result;
    logic          i_ready;

    setup_result_t exp_q [$];
    logic          exp_culled_q [$];
    triangle_t     rand_tris [N_RANDOM];

    logic [31:0]   lcg_state = 32'd38615;
    int            errors = 0;
    int            errors_at_start = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;
    int            cycle_count = 0;
    int            edge_no = 0;
    int            last_out_edge = 0;
    int            stream_seen = 0;
    logic          rand_ready = 1'b0;
    logic          streaming = 1'b0;
    logic          holding = 1'b0;
    logic          first_after_reset = 1'b0;
    setup_result_t held_result;
    logic          held_culled;
    setup_result_t new_exp;
    logic          new_exp_culled;

    tri_setup #(
        .SCREEN_W (DEF_SCREEN_W),
        .SCREEN_H (DEF_SCREEN_H)
    ) i_tri_setup (
        .clk      (clk),
        .rstn     (rstn),
        .i_dv     (i_dv),
        .i_tri    (i_tri),
        .o_ready  (o_ready),
        .o_dv     (o_dv),
        .o_culled (o_culled),
        .o_result (o_result),
        .i_ready  (i_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic fxp_t pix(input int p);
        return fxp_t'(p) <<< FRAC_BITS;
    endfunction

    // Integer part from -100 to 739, random fraction
    function automatic vertex_t random_vertex();
        vertex_t     v;
        logic [31:0] r;
        int          ix;
        int          iy;
        r = lcg_next();
        ix = int'(r[31:16] % 840) - 100;
        v.x = pix(ix) + fxp_t'({16'd0, r[15:0]});
        r = lcg_next();
        iy = int'(r[31:16] % 560) - 100;
        v.y = pix(iy) + fxp_t'({16'd0, r[15:0]});
        v.z = fxp_t'(lcg_next());
        return v;
    endfunction

    function automatic triangle_t pixel_tri(input int x0, input int y0, input int x1,
                                            input int y1, input int x2, input int y2);
        triangle_t t;
        t.v0 = '{x: pix(x0), y: pix(y0), z: pix(1)};
        t.v1 = '{x: pix(x1), y: pix(y1), z: 32'sh0002_8000};
        t.v2 = '{x: pix(x2), y: pix(y2), z: -pix(3)};
        return t;
    endfunction

    // Expected output built from the setup rules
    function automatic setup_result_t expected_setup(input triangle_t t, output logic culled);
        vertex_t       v [3];
        fxp_t          lo_x;
        fxp_t          lo_y;
        fxp_t          hi_x;
        fxp_t          hi_y;
        longint        px;
        longint        py;
        longint        ex;
        longint        ey;
        longint        f;
        int            b;
        setup_result_t r;
        v[0] = t.v0;
        v[1] = t.v1;
        v[2] = t.v2;
        lo_x = v[0].x;
        lo_y = v[0].y;
        hi_x = v[0].x;
        hi_y = v[0].y;
        for (int i = 1; i < 3; i++) begin
            if (v[i].x < lo_x) lo_x = v[i].x;
            if (v[i].y < lo_y) lo_y = v[i].y;
            if (v[i].x > hi_x) hi_x = v[i].x;
            if (v[i].y > hi_y) hi_y = v[i].y;
        end
        r.bbox.tl.x = (lo_x > 0) ? lo_x : fxp_t'(0);
        r.bbox.tl.y = (lo_y > 0) ? lo_y : fxp_t'(0);
        r.bbox.br.x = (hi_x < pix(DEF_SCREEN_W)) ? hi_x : pix(DEF_SCREEN_W);
        r.bbox.br.y = (hi_y < pix(DEF_SCREEN_H)) ? hi_y : pix(DEF_SCREEN_H);
        r.bbox.valid = (r.bbox.br.x > r.bbox.tl.x) && (r.bbox.br.y > r.bbox.tl.y);
        r.area = fxp_t'(0);
        for (int e = 0; e < N_EDGES; e++) begin
            b = (e + 1) % 3;
            px = longint'(r.bbox.tl.x) - longint'(v[e].x);
            py = longint'(r.bbox.tl.y) - longint'(v[e].y);
            ex = longint'(v[b].x) - longint'(v[e].x);
            ey = longint'(v[b].y) - longint'(v[e].y);
            f = px * ey - py * ex;
            // Back to 16.16, upper bits dropped
            r.edges[e].value = fxp_t'(f >>> FRAC_BITS);
            r.edges[e].dx = v[b].y - v[e].y;
            r.edges[e].dy = v[e].x - v[b].x;
            r.area = r.area + r.edges[e].value;
        end
        r.z0 = t.v0.z;
        r.z1 = t.v1.z;
        r.z2 = t.v2.z;
        culled = (r.area <= 0) || !r.bbox.valid;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_result(input setup_result_t exp, input logic exp_culled);
        check_field("bbox", o_result.bbox, exp.bbox);
        for (int e = 0; e < N_EDGES; e++) begin
            check_field($sformatf("edge%0d.value", e), o_result.edges[e].value, exp.edges[e].value);
            check_field($sformatf("edge%0d.dx", e), o_result.edges[e].dx, exp.edges[e].dx);
            check_field($sformatf("edge%0d.dy", e), o_result.edges[e].dy, exp.edges[e].dy);
        end
        check_field("area", o_result.area, exp.area);
        check_field("z0", o_result.z0, exp.z0);
        check_field("z1", o_result.z1, exp.z1);
        check_field("z2", o_result.z2, exp.z2);
        check_field("culled", o_culled, exp_culled);
    endtask

    // Called just after a clock edge, returns one unit after the accepting edge
    task automatic send_tri(input triangle_t t);
        i_tri = t;
        i_dv = 1'b1;
        @(posedge clk);
        while (!o_ready) @(posedge clk);
        #1;
        i_dv = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        wait_drain();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Accepted triangles become expectations
    always @(posedge clk) begin
        if (rstn && i_dv && o_ready) begin
            new_exp = expected_setup(i_tri, new_exp_culled);
            exp_q.push_back(new_exp);
            exp_culled_q.push_back(new_exp_culled);
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            holding = 1'b0;
            first_after_reset = 1'b1;
        end else begin
            edge_no++;
            // Idle outputs and ready right after reset
            if (first_after_reset) begin
                assert (o_ready === 1'b1 && o_dv === 1'b0 && o_culled === 1'b0) else begin
                    $display("CHECK FAILED at time %0t: outputs not idle after reset", $time);
                    errors++;
                end
                first_after_reset = 1'b0;
            end
            if (holding) begin
                assert (o_dv && o_result === held_result && o_culled === held_culled) else begin
                    $display("CHECK FAILED at time %0t: output moved while stalled", $time);
                    errors++;
                end
            end
            holding = o_dv && !i_ready;
            held_result = o_result;
            held_culled = o_culled;
            if (o_dv && i_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("A result came out with no triangle outstanding at time %0t", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    compare_result(exp_q.pop_front(), exp_culled_q.pop_front());
                end
                if (streaming && stream_seen > 0) begin
                    assert (edge_no == last_out_edge + 1) else begin
                        $display("CHECK FAILED at time %0t: gap in streamed output", $time);
                        errors++;
                    end
                end
                if (streaming) stream_seen++;
                last_out_edge = edge_no;
            end
        end
    end

    // Upper generator bits, ready about three cycles in four
    always @(posedge clk) begin
        if (rand_ready) begin
            #1;
            i_ready = (lcg_next() >> 30) != 0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d results outstanding",
                     cycle_count, exp_q.size());
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        i_dv = 1'b0;
        i_tri = '0;
        i_ready = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_tris[i].v0 = random_vertex();
            rand_tris[i].v1 = random_vertex();
            rand_tris[i].v2 = random_vertex();
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        send_tri(pixel_tri(100, 50, 80, 200, 300, 150));
        end_test("1 inside triangle");

        send_tri(pixel_tri(-50, -40, -30, 420, 700, 100));
        end_test("2 clamped box");

        send_tri(pixel_tri(100, 50, 300, 150, 80, 200));
        end_test("3 clockwise culled");

        send_tri(pixel_tri(-200, 10, -100, 10, -150, 100));
        send_tri(pixel_tri(10, 50, 200, 50, 100, 50));
        end_test("4 empty box culled");

        // Pipeline fills, then the output stalls twice
        i_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 5; i++) begin
                    send_tri(pixel_tri(10 + 20 * i, 10, 5 + 20 * i, 60, 40 + 20 * i, 40));
                end
            end
            begin
                repeat (12) @(posedge clk);
                #1 i_ready = 1'b1;
                @(posedge clk);
                #1 i_ready = 1'b0;
                repeat (4) @(posedge clk);
                #1 i_ready = 1'b1;
            end
        join
        end_test("5 back-pressure");

        streaming = 1'b1;
        stream_seen = 0;
        for (int i = 0; i < N_STREAM; i++) send_tri(rand_tris[i]);
        wait_drain();
        streaming = 1'b0;
        rand_ready = 1'b1;
        for (int i = N_STREAM; i < N_RANDOM; i++) send_tri(rand_tris[i]);
        rand_ready = 1'b0;
        @(posedge clk);
        #1 i_ready = 1'b1;
        end_test("6 random stream");

        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
fxp_pkg.sv
setup_pkg.sv
tri_capture.sv
edge_unit.sv
setup_collect.sv
tri_setup.sv
tb_tri_setup.sv
